//--- logic/vip_pkg.sv
//************************************************
// pixel types for the video data path
// rgb565 pixel, channel widths, three-line column
//************************************************
package vip_pkg;

    // field widths of one rgb565 pixel
    localparam int R_W   = 5;
    localparam int G_W   = 6;
    localparam int B_W   = 5;
    localparam int PIX_W = R_W + G_W + B_W;   // 16

    // packed pixel, red in the top bits
    typedef logic [PIX_W-1:0] rgb565_t;       // {r[4:0], g[5:0], b[4:0]}

    typedef logic [R_W-1:0]   chan5_t;        // red or blue
    typedef logic [G_W-1:0]   chan6_t;        // green, also the sort width

    //************************************************
    // one column of the 3x3 window
    //************************************************
    // same column index taken from three lines,
    // oldest line on top
    typedef struct packed {
        rgb565_t top;   // line y-2
        rgb565_t mid;   // line y-1
        rgb565_t bot;   // line y, pixel just in
    } pix_col_t;

endpackage

//--- logic/frame_pkg.sv
//************************************************
// frame geometry, pipeline latency and sync types
//************************************************
package frame_pkg;

    // largest supported frame
    localparam int H_MAX = 1280;               // pixels per line, line buffer depth
    localparam int V_MAX = 1024;               // lines per frame

    localparam int COL_W = $clog2(H_MAX);      // 11
    localparam int ROW_W = $clog2(V_MAX);      // 10

    typedef logic [COL_W-1:0] col_t;
    typedef logic [ROW_W-1:0] row_t;

    // counters stop here
    localparam col_t COL_LAST = col_t'(H_MAX - 1);
    localparam row_t ROW_LAST = row_t'(V_MAX - 1);

    // pre to post delay in clocks
    localparam int PIPE_LAT = 4;

    // first col and row that own a full 3x3 window
    localparam int WIN_EDGE = 2;

    // camera style sync bundle
    typedef struct packed {
        logic vsync;   // high in frame gap
        logic href;    // high for active line
        logic de;      // pixel valid
    } sync_t;

    // output gating after reset
    typedef enum logic {
        WAIT_FRAME = 1'b0,   // partial frame, hold enables low
        RUN        = 1'b1    // frame aligned, pass through
    } frame_state_t;

endpackage

//--- logic/pixel_counter.sv
//************************************************
// column and row position of the incoming pixel
//************************************************
`timescale 1ns/10ps

module pixel_counter
    import frame_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  sync_t sync_in,
    output col_t  col,       // index of the pixel on de
    output row_t  row        // index of the current line
);

    logic href_q;            // last href, edge detect
    logic vsync_q;           // last vsync, edge detect
    logic line_end;
    logic frame_start;

    assign line_end    = href_q & ~sync_in.href;      // href falling
    assign frame_start = sync_in.vsync & ~vsync_q;    // vsync rising

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            href_q  <= 1'b0;
            vsync_q <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else begin
            href_q  <= sync_in.href;
            vsync_q <= sync_in.vsync;

            // column, one step per valid pixel
            if (frame_start || line_end)
                col <= '0;
            else if (sync_in.de && col != COL_LAST)
                col <= col + 1'b1;               // hold at last column

            // row, one step per finished line
            if (frame_start)
                row <= '0;
            else if (line_end && row != ROW_LAST)
                row <= row + 1'b1;
        end
    end

endmodule

//--- logic/frame_fsm.sv
//************************************************
// frame start gating, sync delay line and border
// flag, aligned to the median pipeline
//************************************************
`timescale 1ns/10ps

module frame_fsm
    import frame_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  sync_t sync_in,
    input  col_t  col,
    input  row_t  row,
    output sync_t sync_out,   // post side sync
    output logic  border      // zero the median output
);

    // one slot of the delay line
    typedef struct packed {
        sync_t sync;
        logic  border;
    } stage_t;

    frame_state_t state;
    logic         vsync_q;                 // last vsync
    logic         run;
    stage_t       stage_in;
    stage_t       pipe [PIPE_LAT];         // pipe[k] is k+1 clocks late

    //************************************************
    // frame state machine
    //************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WAIT_FRAME;
            vsync_q <= 1'b0;
        end else begin
            vsync_q <= sync_in.vsync;
            case (state)
                WAIT_FRAME: begin
                    // first vsync rise, next frame is whole
                    if (sync_in.vsync && !vsync_q)
                        state <= RUN;
                end
                RUN:     state <= RUN;     // stays until reset
                default: state <= WAIT_FRAME;
            endcase
        end
    end

    assign run = (state == RUN);

    // only place the enables get gated
    always_comb begin
        stage_in.sync.vsync = sync_in.vsync;          // vsync always follows
        stage_in.sync.href  = sync_in.href & run;
        stage_in.sync.de    = sync_in.de & run;
        stage_in.border     = (col < col_t'(WIN_EDGE)) || (row < row_t'(WIN_EDGE));
    end

    //************************************************
    // delay line, matches the data path latency
    //************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_LAT; i++)
                pipe[i] <= '0;
        end else begin
            pipe[0] <= stage_in;
            for (int i = 1; i < PIPE_LAT; i++)
                pipe[i] <= pipe[i-1];
        end
    end

    assign sync_out = pipe[PIPE_LAT-1].sync;

    // median result register loads one clock before post,
    // so border is tapped a stage early
    assign border = pipe[PIPE_LAT-2].border;

endmodule

//--- logic/line_buffer.sv
//************************************************
// two line memories, three vertical pixels per col
//************************************************
`timescale 1ns/10ps

module line_buffer
    import vip_pkg::*;
    import frame_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  rgb565_t  pix,        // pixel of line y
    input  logic     de,
    input  col_t     col,        // column of pix
    output pix_col_t taps        // lines y-2, y-1, y at col
);

    rgb565_t line_y1 [H_MAX];    // previous line
    rgb565_t line_y2 [H_MAX];    // line before that

    //************************************************
    // line memories
    //************************************************
    // old contents read in the same clock as the write,
    // y-1 word moves down to y-2
    always_ff @(posedge clk) begin
        if (de) begin
            line_y2[col] <= line_y1[col];
            line_y1[col] <= pix;
        end
    end

    // tap register, holds between pixels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            taps <= '0;
        end else if (de) begin
            taps.top <= line_y2[col];    // y-2
            taps.mid <= line_y1[col];    // y-1
            taps.bot <= pix;             // y, straight through
        end
    end

endmodule

//--- logic/median3x3.sv
//************************************************
// 3x3 median per colour channel
// window shift, row sort, median of column sorts
//************************************************
`timescale 1ns/10ps

module median3x3
    import vip_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  pix_col_t taps,       // newest column
    input  logic     de,         // taps valid
    input  logic     border,     // aligned with the last stage
    output rgb565_t  post_rgb
);

    // sorted triple of one channel
    typedef struct packed {
        chan6_t lo;
        chan6_t mi;
        chan6_t hi;
    } sort3_t;

    pix_col_t win [3];           // win[0] newest, win[2] oldest
    logic     sort_en;           // window moved last clock
    logic     med_en;            // sort regs moved last clock
    sort3_t   srt_d [3][3];      // [line][channel]
    sort3_t   srt_q [3][3];
    chan6_t   med_d [3];         // per channel result
    rgb565_t  med_pix;

    //************************************************
    // compare helpers
    //************************************************
    function automatic chan6_t min2(input chan6_t a, input chan6_t b);
        return (a < b) ? a : b;
    endfunction

    function automatic chan6_t max2(input chan6_t a, input chan6_t b);
        return (a < b) ? b : a;
    endfunction

    // three comparators deep
    function automatic sort3_t sort3(input chan6_t a, input chan6_t b, input chan6_t c);
        chan6_t lo_ab;
        chan6_t hi_ab;
        sort3_t s;
        lo_ab = min2(a, b);
        hi_ab = max2(a, b);
        s.lo  = min2(lo_ab, c);
        s.hi  = max2(hi_ab, c);
        s.mi  = max2(lo_ab, min2(hi_ab, c));
        return s;
    endfunction

    function automatic chan6_t med3(input chan6_t a, input chan6_t b, input chan6_t c);
        sort3_t s;
        s = sort3(a, b, c);
        return s.mi;
    endfunction

    // one line of a window column
    function automatic rgb565_t line_of(input pix_col_t c, input int unsigned ln);
        case (ln)
            0:       return c.top;
            1:       return c.mid;
            default: return c.bot;
        endcase
    endfunction

    // channel 0 red, 1 green, 2 blue, 5 bit ones zero extended
    function automatic chan6_t chan_of(input rgb565_t p, input int unsigned ch);
        chan5_t r;
        chan6_t g;
        chan5_t b;
        r = p[PIX_W-1 -: R_W];
        g = p[B_W +: G_W];
        b = p[B_W-1:0];
        case (ch)
            0:       return {1'b0, r};
            1:       return g;
            default: return {1'b0, b};
        endcase
    endfunction

    //************************************************
    // stage 0, window shift
    //************************************************
    always_ff @(posedge clk) begin
        if (de) begin
            win[0] <= taps;
            win[1] <= win[0];
            win[2] <= win[1];
        end
    end

    // stage enables follow de down the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sort_en <= 1'b0;
            med_en  <= 1'b0;
        end else begin
            sort_en <= de;
            med_en  <= sort_en;
        end
    end

    // stage 1, sort each line of three
    always_comb begin
        for (int ln = 0; ln < 3; ln++) begin
            for (int ch = 0; ch < 3; ch++) begin
                srt_d[ln][ch] = sort3(chan_of(line_of(win[0], ln), ch),
                                      chan_of(line_of(win[1], ln), ch),
                                      chan_of(line_of(win[2], ln), ch));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sort_en)
            srt_q <= srt_d;
    end

    // stage 2, max of mins, median of mids, min of maxes
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            med_d[ch] = med3(max2(max2(srt_q[0][ch].lo, srt_q[1][ch].lo), srt_q[2][ch].lo),
                             med3(srt_q[0][ch].mi, srt_q[1][ch].mi, srt_q[2][ch].mi),
                             min2(min2(srt_q[0][ch].hi, srt_q[1][ch].hi), srt_q[2][ch].hi));
        end
        med_pix = {med_d[0][R_W-1:0], med_d[1], med_d[2][B_W-1:0]};   // repack rgb565
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            post_rgb <= '0;
        else if (med_en)
            post_rgb <= border ? '0 : med_pix;   // no full window, black
    end

endmodule

//--- logic/vip.sv
//************************************************
// video image processing top, 3x3 median filter
//************************************************
`timescale 1ns/10ps

module vip
    import vip_pkg::*;
    import frame_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // stream in
    input  logic    pre_frame_vsync,
    input  logic    pre_frame_href,
    input  logic    pre_frame_de,
    input  rgb565_t pre_rgb,
    // stream out, 4 clocks later
    output logic    post_frame_vsync,
    output logic    post_frame_href,
    output logic    post_frame_de,
    output rgb565_t post_rgb
);

    sync_t    sync_in;
    sync_t    sync_out;
    col_t     col;
    row_t     row;
    pix_col_t taps;
    logic     de_q;              // de, aligned with taps
    logic     border;

    assign sync_in = '{vsync: pre_frame_vsync, href: pre_frame_href, de: pre_frame_de};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            de_q <= 1'b0;
        else
            de_q <= pre_frame_de;
    end

    pixel_counter pixel_counter_i (
        .clk     (clk     ),
        .rst_n   (rst_n   ),
        .sync_in (sync_in ),
        .col     (col     ),
        .row     (row     )
    );

    frame_fsm frame_fsm_i (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .sync_in  (sync_in  ),
        .col      (col      ),
        .row      (row      ),
        .sync_out (sync_out ),
        .border   (border   )
    );

    line_buffer line_buffer_i (
        .clk   (clk          ),
        .rst_n (rst_n        ),
        .pix   (pre_rgb      ),
        .de    (pre_frame_de ),
        .col   (col          ),
        .taps  (taps         )
    );

    median3x3 median3x3_i (
        .clk      (clk      ),
        .rst_n    (rst_n    ),
        .taps     (taps     ),
        .de       (de_q     ),
        .border   (border   ),
        .post_rgb (post_rgb )
    );

    assign post_frame_vsync = sync_out.vsync;
    assign post_frame_href  = sync_out.href;
    assign post_frame_de    = sync_out.de;

endmodule

//--- bench/vip_model.svh
//************************************************
// reference 3x3 median and expected output queue
//************************************************
`ifndef VIP_MODEL_SVH
`define VIP_MODEL_SVH

rgb565_t frame_pix [FR_MAX_H][FR_MAX_W];   // pixels of the frame being sent
rgb565_t exp_q [$];                         // expected post_rgb, raster order

// median of one channel over the window ending at (x, y)
function automatic int unsigned chan_median(input int x, input int y,
                                            input int lsb, input int width);
    int unsigned v [9];
    int unsigned t;
    int          n;
    n = 0;
    for (int dy = -2; dy <= 0; dy++) begin
        for (int dx = -2; dx <= 0; dx++) begin
            v[n] = 32'((frame_pix[y + dy][x + dx] >> lsb) & ((1 << width) - 1));
            n++;
        end
    end
    // plain bubble sort, entry 4 is the middle one
    for (int i = 0; i < 8; i++) begin
        for (int j = 0; j < 8 - i; j++) begin
            if (v[j] > v[j + 1]) begin
                t        = v[j];
                v[j]     = v[j + 1];
                v[j + 1] = t;
            end
        end
    end
    return v[4];
endfunction

// output for input pixel (x, y), window centre at (x-1, y-1)
function automatic rgb565_t expect_pixel(input int x, input int y);
    if (x < 2 || y < 2)
        return '0;                          // no full window
    return {5'(chan_median(x, y, 11, 5)),   // red
            6'(chan_median(x, y, 5, 6)),    // green
            5'(chan_median(x, y, 0, 5))};   // blue
endfunction

// whole frame through the model
function automatic void push_model(input int w, input int h);
    for (int y = 0; y < h; y++)
        for (int x = 0; x < w; x++)
            exp_q.push_back(expect_pixel(x, y));
endfunction

// frames whose filtered result is one colour
function automatic void push_flat(input int w, input int h, input rgb565_t c);
    for (int y = 0; y < h; y++)
        for (int x = 0; x < w; x++)
            exp_q.push_back((x < 2 || y < 2) ? '0 : c);
endfunction

`endif

//--- bench/vip_tb.sv
//************************************************
// testbench for the vip 3x3 median filter
// random frames, model compare, sync alignment
//************************************************
`timescale 1ns/10ps

module vip_tb
    import vip_pkg::*;
    import frame_pkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 16;
    localparam int SEED        = 32'hb3ea;
    localparam int FR_MAX_W    = 32;
    localparam int FR_MAX_H    = 10;
    localparam int VSYNC_GAP   = 8;          // vsync high between frames
    localparam int LEAD        = 4;          // vsync low to first line
    localparam int HREF_GAP    = 6;          // blank clocks between lines
    localparam int NOISE_RATE  = 2;          // 1 in N grid sites get an outlier
    localparam int DE_GAP_RATE = 4;          // 1 in N pixels preceded by a hole
    localparam int MODE_FLAT   = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_NOISE  = 2;
    localparam int N_FRAMES    = 6;
    localparam int FRAME_CYC   = VSYNC_GAP + LEAD + FR_MAX_H * (2 * FR_MAX_W + HREF_GAP);
    localparam int TIMEOUT_NS  = (RST_CYCLES + N_FRAMES * FRAME_CYC + 200) * CLK_PERIOD;

    logic    clk;
    logic    rst_n;
    logic    pre_frame_vsync;
    logic    pre_frame_href;
    logic    pre_frame_de;
    rgb565_t pre_rgb;
    logic    post_frame_vsync;
    logic    post_frame_href;
    logic    post_frame_de;
    rgb565_t post_rgb;

    int      errors;
    int      test_base;                      // errors before current test
    int      de_count;                       // checked output pixels
    int      pix_total;                      // pixels sent in checked frames
    int      sync_cycles;
    logic    skip_data;                      // data of the partial frame not compared
    sync_t   hist [PIPE_LAT];                // hist[k] holds the sync of k+1 clocks ago
    logic    run_ref;                        // model of the frame state
    logic    vsync_ref;

    `include "vip_model.svh"

    vip vip_i (
        .clk              (clk              ),
        .rst_n            (rst_n            ),
        .pre_frame_vsync  (pre_frame_vsync  ),
        .pre_frame_href   (pre_frame_href   ),
        .pre_frame_de     (pre_frame_de     ),
        .pre_rgb          (pre_rgb          ),
        .post_frame_vsync (post_frame_vsync ),
        .post_frame_href  (post_frame_href  ),
        .post_frame_de    (post_frame_de    ),
        .post_rgb         (post_rgb         )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //************************************************
    // stimulus helpers
    //************************************************
    task automatic fill_frame(input int w, input int h, input int mode, input rgb565_t base);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                if (mode == MODE_RANDOM)
                    frame_pix[y][x] = rgb565_t'($urandom);
                else if (mode == MODE_NOISE && x % 3 == 0 && y % 3 == 0
                         && $urandom_range(NOISE_RATE - 1) == 0)
                    frame_pix[y][x] = rgb565_t'($urandom);   // one per window at most
                else
                    frame_pix[y][x] = base;
            end
        end
    endtask

    // vsync gap then h lines of w pixels
    // rst_line >= 0 pulses reset in the middle of that line
    task automatic send_frame(input int w, input int h, input bit de_gaps, input int rst_line);
        repeat (VSYNC_GAP) begin
            @(posedge clk);
            pre_frame_vsync <= 1'b1;
            pre_frame_href  <= 1'b0;
            pre_frame_de    <= 1'b0;
        end
        repeat (LEAD) begin
            @(posedge clk);
            pre_frame_vsync <= 1'b0;
        end
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                if (de_gaps && $urandom_range(DE_GAP_RATE - 1) == 0) begin
                    @(posedge clk);
                    pre_frame_href <= 1'b1;          // hole inside href
                    pre_frame_de   <= 1'b0;
                end
                @(posedge clk);
                pre_frame_href <= 1'b1;
                pre_frame_de   <= 1'b1;
                pre_rgb        <= frame_pix[y][x];
                if (y == rst_line && x == w / 2)
                    rst_n <= 1'b0;
                if (y == rst_line && x == w / 2 + 3)
                    rst_n <= 1'b1;
            end
            repeat (HREF_GAP) begin
                @(posedge clk);
                pre_frame_href <= 1'b0;
                pre_frame_de   <= 1'b0;
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (PIPE_LAT + 2) @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s done, %0d errors", num, name, errors - test_base);
        test_base = errors;
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s expected %0b actual %0b", $time, name, exp, act);
        end
    endtask

    //************************************************
    // monitor sampled mid cycle
    //************************************************
    always @(negedge clk) begin
        rgb565_t exp_pix;
        if (!rst_n) begin
            for (int i = 0; i < PIPE_LAT; i++)
                hist[i] = '0;                        // delay line clears on reset
            run_ref   = 1'b0;
            vsync_ref = 1'b0;
        end else begin
            compare_bit("post_frame_vsync", hist[PIPE_LAT-1].vsync, post_frame_vsync);
            compare_bit("post_frame_href", hist[PIPE_LAT-1].href, post_frame_href);
            compare_bit("post_frame_de", hist[PIPE_LAT-1].de, post_frame_de);
            sync_cycles++;
            if (post_frame_de && !skip_data) begin
                de_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("t=%0t output pixel arrived with nothing expected", $time);
                end else begin
                    exp_pix = exp_q.pop_front();
                    if (post_rgb !== exp_pix) begin
                        errors++;
                        $display("MISMATCH t=%0t post_rgb expected %h actual %h",
                                 $time, exp_pix, post_rgb);
                    end
                end
            end
            for (int i = PIPE_LAT - 1; i > 0; i--)
                hist[i] = hist[i-1];
            hist[0].vsync = pre_frame_vsync;
            hist[0].href  = pre_frame_href & run_ref;   // gated until first vsync rise
            hist[0].de    = pre_frame_de & run_ref;
            if (pre_frame_vsync && !vsync_ref)
                run_ref = 1'b1;
            vsync_ref = pre_frame_vsync;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, run did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

    //************************************************
    // test sequence
    //************************************************
    initial begin
        rgb565_t base;
        void'($urandom(SEED));
        errors          = 0;
        test_base       = 0;
        de_count        = 0;
        pix_total       = 0;
        sync_cycles     = 0;
        skip_data       = 1'b0;
        rst_n           = 1'b0;
        pre_frame_vsync = 1'b0;
        pre_frame_href  = 1'b0;
        pre_frame_de    = 1'b0;
        pre_rgb         = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        base = rgb565_t'($urandom);
        fill_frame(24, 8, MODE_FLAT, base);
        push_flat(24, 8, base);
        pix_total += 24 * 8;
        send_frame(24, 8, 1'b0, -1);
        wait_drain();
        report_test(1, "flat frame");

        fill_frame(32, 10, MODE_RANDOM, '0);
        push_model(32, 10);
        pix_total += 32 * 10;
        send_frame(32, 10, 1'b0, -1);
        wait_drain();
        report_test(2, "random frame");

        base = rgb565_t'($urandom);
        fill_frame(30, 9, MODE_NOISE, base);
        push_flat(30, 9, base);                  // outliers must vanish
        pix_total += 30 * 9;
        send_frame(30, 9, 1'b0, -1);
        wait_drain();
        report_test(3, "impulse noise");

        fill_frame(20, 6, MODE_RANDOM, '0);
        push_model(20, 6);
        pix_total += 20 * 6;
        send_frame(20, 6, 1'b1, -1);             // de holes inside href
        wait_drain();
        if (de_count != pix_total) begin
            errors++;
            $display("MISMATCH t=%0t post_frame_de count expected %0d actual %0d",
                     $time, pix_total, de_count);
        end
        report_test(4, "sync alignment");

        skip_data = 1'b1;
        fill_frame(24, 8, MODE_RANDOM, '0);
        send_frame(24, 8, 1'b0, 3);              // reset in line 3
        skip_data = 1'b0;
        fill_frame(24, 8, MODE_RANDOM, '0);
        push_model(24, 8);
        pix_total += 24 * 8;
        send_frame(24, 8, 1'b0, -1);
        wait_drain();
        report_test(5, "partial frame after reset");

        $display("%0d of %0d pixels checked, %0d sync cycles checked, %0d errors",
                 de_count, pix_total, sync_cycles, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- all.f
+incdir+bench
logic/vip_pkg.sv
logic/frame_pkg.sv
logic/pixel_counter.sv
logic/frame_fsm.sv
logic/line_buffer.sv
logic/median3x3.sv
logic/vip.sv
bench/vip_tb.sv

//--- Makefile
# Verilator build and run of the vip median filter testbench

TOP := vip_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
